/* include/wl_macros.svh */
// Address map and sizing for the memory subsystem
// Host regions, memory depths and control register indices

`ifndef WL_MACROS_SVH
`define WL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Host address map
//////////////////////////////////////////////////////////////////////

`define WL_INSTR_BASE 32'h0000_1000
`define WL_DATA_BASE 32'h0000_2000
`define WL_CSR_BASE 32'h0000_3000

// Every region is this size and aligned to its base
`define WL_REGION_BYTES 32'd1024

//////////////////////////////////////////////////////////////////////
// Memory depths and register indices
//////////////////////////////////////////////////////////////////////

`define WL_INSTR_WORDS 256
`define WL_DATA_WORDS 256

// Control register word indices
`define WL_CSR_EOC_IDX 0
`define WL_CSR_SCRATCH_IDX 1

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -f wl.f --top-module wl_tb -o wl_sim

# The log decides the result, so the simulator exit code is not used here
./obj_dir/wl_sim 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "Regression passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0

/* src/wl_csr_regs.sv */
// Control registers
// End-of-computation value and a scratch word, one-cycle response

`include "wl_macros.svh"

module wl_csr_regs (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_i,
  input  logic             we_i,
  input  logic [1:0]       idx_i,
  input  wl_pkg::wl_data_t wdata_i,
  output logic             rsp_valid_o,
  output wl_pkg::wl_data_t rdata_o,
  output wl_pkg::wl_data_t eoc_o
);

  import wl_pkg::*;

  wl_data_t eoc_q;
  wl_data_t scratch_q;
  wl_data_t rdata_q;
  logic     rsp_valid_q;

  // Register writes; other indices are ignored
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q       <= '0;
      scratch_q   <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i;
      if (req_i && we_i) begin
        case (idx_i)
          `WL_CSR_EOC_IDX:     eoc_q     <= wdata_i;
          `WL_CSR_SCRATCH_IDX: scratch_q <= wdata_i;
          default:             ;
        endcase
      end
    end
  end

  // Read data, zero for writes and unused indices
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_q <= '0;
      end else begin
        case (idx_i)
          `WL_CSR_EOC_IDX:     rdata_q <= eoc_q;
          `WL_CSR_SCRATCH_IDX: rdata_q <= scratch_q;
          default:             rdata_q <= '0;
        endcase
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign eoc_o       = eoc_q;

endmodule

/* src/wl_data_mem.sv */
// Data memory
// 256 words; every request gets a response strobe one cycle later

`include "wl_macros.svh"

module wl_data_mem (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_i,
  input  logic             we_i,
  input  wl_pkg::wl_didx_t idx_i,
  input  wl_pkg::wl_data_t wdata_i,
  output logic             rsp_valid_o,
  output wl_pkg::wl_data_t rdata_o
);

  import wl_pkg::*;

  wl_data_t mem_q [`WL_DATA_WORDS];
  wl_data_t rdata_q;
  logic     rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[idx_i] <= wdata_i;
        rdata_q      <= '0;
      end else begin
        rdata_q <= mem_q[idx_i];
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;

endmodule

/* src/wl_host_decode.sv */
// Host address decoder
// Steers each host request to one target with a region-relative index,
// answers unmapped addresses itself and merges the target responses

`include "wl_macros.svh"

module wl_host_decode (
  input  logic             clk_i,
  input  logic             reset_i,
  // Host request
  input  logic             host_req_i,
  input  logic             host_we_i,
  input  wl_pkg::wl_addr_t host_addr_i,
  input  wl_pkg::wl_data_t host_wdata_i,
  // Target responses
  input  logic             ir_rsp_valid_i,
  input  wl_pkg::wl_data_t ir_rdata_i,
  input  logic             iw_ack_i,
  input  logic             dm_rsp_valid_i,
  input  wl_pkg::wl_data_t dm_rdata_i,
  input  logic             cr_rsp_valid_i,
  input  wl_pkg::wl_data_t cr_rdata_i,
  // Host response
  output logic             host_rsp_valid_o,
  output wl_pkg::wl_data_t host_rdata_o,
  output logic             host_err_o,
  // Target requests
  output logic             ir_req_o,
  output logic             iw_req_o,
  output wl_pkg::wl_iidx_t idx_o,
  output logic             dm_req_o,
  output logic             dm_we_o,
  output logic             cr_req_o,
  output logic             cr_we_o,
  output wl_pkg::wl_data_t wdata_o,
  output wl_pkg::wl_didx_t dm_idx_o,
  output logic [1:0]       cr_idx_o
);

  import wl_pkg::*;

  wl_target_e target;
  wl_addr_t   region;
  wl_addr_t   offset;
  logic       err_q;

  //////////////////////////////////////////////////////////////////////
  // Region match and offset remap
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    region = host_addr_i & ~(`WL_REGION_BYTES - 32'd1);
    offset = host_addr_i & (`WL_REGION_BYTES - 32'd1);
    if (region == `WL_INSTR_BASE) begin
      target = target_instr;
    end else if (region == `WL_DATA_BASE) begin
      target = target_data;
    end else if (region == `WL_CSR_BASE) begin
      target = target_csr;
    end else begin
      target = target_none;
    end
  end

  // Instruction reads go through the arbiter, writes straight to memory
  assign ir_req_o = host_req_i && (target == target_instr) && !host_we_i;
  assign iw_req_o = host_req_i && (target == target_instr) && host_we_i;
  assign dm_req_o = host_req_i && (target == target_data);
  assign cr_req_o = host_req_i && (target == target_csr);

  assign dm_we_o  = host_we_i;
  assign cr_we_o  = host_we_i;
  assign wdata_o  = host_wdata_i;

  // Word index sits in bits 9:2 of the offset
  assign idx_o    = offset[9:2];
  assign dm_idx_o = offset[9:2];
  assign cr_idx_o = offset[3:2];

  //////////////////////////////////////////////////////////////////////
  // Response merge
  //////////////////////////////////////////////////////////////////////

  // Unmapped access answered here one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= host_req_i && (target == target_none);
    end
  end

  assign host_rsp_valid_o = ir_rsp_valid_i | iw_ack_i | dm_rsp_valid_i |
                            cr_rsp_valid_i | err_q;
  assign host_err_o = err_q;

  // Only one request is ever in flight, so at most one strobe is high
  always_comb begin
    if (ir_rsp_valid_i) begin
      host_rdata_o = ir_rdata_i;
    end else if (dm_rsp_valid_i) begin
      host_rdata_o = dm_rdata_i;
    end else if (cr_rsp_valid_i) begin
      host_rdata_o = cr_rdata_i;
    end else begin
      host_rdata_o = '0;
    end
  end

endmodule

/* src/wl_instr_arbiter.sv */
// Instruction memory read arbiter
// Fetch always wins; a losing host read waits in a one-entry slot
// until the first cycle without a fetch

module wl_instr_arbiter (
  input  logic             clk_i,
  input  logic             reset_i,
  // Fetch side
  input  logic             fetch_valid_i,
  input  wl_pkg::wl_addr_t fetch_addr_i,
  // Host read side
  input  logic             host_req_i,
  input  wl_pkg::wl_iidx_t host_idx_i,
  // Memory read port
  input  wl_pkg::wl_data_t mem_rdata_i,
  output wl_pkg::wl_data_t fetch_data_o,
  output logic             host_rsp_valid_o,
  output wl_pkg::wl_data_t host_rdata_o,
  output logic             mem_re_o,
  output wl_pkg::wl_iidx_t mem_idx_o
);

  import wl_pkg::*;

  logic     pend_q;
  wl_iidx_t pend_idx_q;
  logic     host_gnt_q;

  logic     host_want;
  wl_iidx_t host_idx;
  logic     host_gnt;

  // New request and pending slot never coexist
  assign host_want = host_req_i | pend_q;
  assign host_idx  = pend_q ? pend_idx_q : host_idx_i;
  assign host_gnt  = host_want && !fetch_valid_i;

  assign mem_re_o  = fetch_valid_i | host_gnt;
  assign mem_idx_o = fetch_valid_i ? fetch_addr_i[9:2] : host_idx;

  //////////////////////////////////////////////////////////////////////
  // Pending slot and grant owner
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q     <= 1'b0;
      host_gnt_q <= 1'b0;
    end else begin
      host_gnt_q <= host_gnt;
      if (host_want && fetch_valid_i) begin
        pend_q <= 1'b1;
      end else if (host_gnt) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Capture the index of a host read that lost to a fetch
  always_ff @(posedge clk_i) begin
    if (host_req_i && fetch_valid_i) begin
      pend_idx_q <= host_idx_i;
    end
  end

  // Steer read data by last cycle's winner
  assign host_rsp_valid_o = host_gnt_q;
  assign host_rdata_o     = host_gnt_q ? mem_rdata_i : '0;
  assign fetch_data_o     = host_gnt_q ? '0 : mem_rdata_i;

endmodule

/* src/wl_instr_mem.sv */
// Instruction memory
// 256 words, one registered read port and one write port with ack

`include "wl_macros.svh"

module wl_instr_mem (
  input  logic             clk_i,
  // Read port
  input  logic             re_i,
  input  wl_pkg::wl_iidx_t ridx_i,
  // Write port
  input  logic             we_i,
  input  wl_pkg::wl_iidx_t widx_i,
  input  wl_pkg::wl_data_t wdata_i,
  output wl_pkg::wl_data_t rdata_o,
  output logic             w_ack_o
);

  import wl_pkg::*;

  wl_data_t mem_q [`WL_INSTR_WORDS];
  wl_data_t rdata_q;
  logic     w_ack_q;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Same-cycle read of a word being written returns the old word
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_q <= mem_q[ridx_i];
    end
    if (we_i) begin
      mem_q[widx_i] <= wdata_i;
    end
  end

  // Write acknowledge one cycle after the write
  always_ff @(posedge clk_i) begin
    w_ack_q <= we_i;
  end

  assign rdata_o = rdata_q;
  assign w_ack_o = w_ack_q;

endmodule

/* src/wl_pkg.sv */
// Shared types for the memory subsystem
// Word and index vectors plus the decoded host target

package wl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Byte address on the host and fetch ports
  typedef logic [31:0] wl_addr_t;

  // Data and instruction word
  typedef logic [31:0] wl_data_t;

  // Word index into the instruction memory (256 words)
  typedef logic [7:0] wl_iidx_t;

  // Word index into the data memory (256 words)
  typedef logic [7:0] wl_didx_t;

  //////////////////////////////////////////////////////////////////////
  // Host target select
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    target_instr,
    target_data,
    target_csr,
    // Address outside every region
    target_none
  } wl_target_e;

endpackage

/* src/wl_top.sv */
// Memory subsystem top level
// Host port reaches instruction memory, data memory and control registers;
// the fetch port shares the instruction memory read port with priority

module wl_top (
  input  logic             clk_i,
  input  logic             reset_i,
  // Host port
  input  logic             host_req_i,
  input  logic             host_we_i,
  input  wl_pkg::wl_addr_t host_addr_i,
  input  wl_pkg::wl_data_t host_wdata_i,
  output logic             host_rsp_valid_o,
  output wl_pkg::wl_data_t host_rdata_o,
  output logic             host_err_o,
  // Fetch port
  input  logic             fetch_valid_i,
  input  wl_pkg::wl_addr_t fetch_addr_i,
  output wl_pkg::wl_data_t fetch_data_o,
  // End of computation value
  output wl_pkg::wl_data_t eoc_o
);

  import wl_pkg::*;

  // Decoder to targets
  logic     ir_req;
  logic     iw_req;
  wl_iidx_t idx;
  logic     dm_req;
  logic     dm_we;
  wl_didx_t dm_idx;
  logic     cr_req;
  logic     cr_we;
  logic [1:0] cr_idx;
  wl_data_t wdata;

  // Targets back to decoder
  logic     ir_rsp_valid;
  wl_data_t ir_rdata;
  logic     iw_ack;
  logic     dm_rsp_valid;
  wl_data_t dm_rdata;
  logic     cr_rsp_valid;
  wl_data_t cr_rdata;

  // Arbitrated instruction memory read port
  logic     mem_re;
  wl_iidx_t mem_idx;
  wl_data_t mem_rdata;

  //////////////////////////////////////////////////////////////////////
  // Host address decode
  //////////////////////////////////////////////////////////////////////

  wl_host_decode i_host_decode (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .host_req_i       (host_req_i),
    .host_we_i        (host_we_i),
    .host_addr_i      (host_addr_i),
    .host_wdata_i     (host_wdata_i),
    .ir_rsp_valid_i   (ir_rsp_valid),
    .ir_rdata_i       (ir_rdata),
    .iw_ack_i         (iw_ack),
    .dm_rsp_valid_i   (dm_rsp_valid),
    .dm_rdata_i       (dm_rdata),
    .cr_rsp_valid_i   (cr_rsp_valid),
    .cr_rdata_i       (cr_rdata),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rdata_o     (host_rdata_o),
    .host_err_o       (host_err_o),
    .ir_req_o         (ir_req),
    .iw_req_o         (iw_req),
    .idx_o            (idx),
    .dm_req_o         (dm_req),
    .dm_we_o          (dm_we),
    .cr_req_o         (cr_req),
    .cr_we_o          (cr_we),
    .wdata_o          (wdata),
    .dm_idx_o         (dm_idx),
    .cr_idx_o         (cr_idx)
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction memory and its read arbiter
  //////////////////////////////////////////////////////////////////////

  wl_instr_arbiter i_instr_arbiter (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_addr_i     (fetch_addr_i),
    .host_req_i       (ir_req),
    .host_idx_i       (idx),
    .mem_rdata_i      (mem_rdata),
    .fetch_data_o     (fetch_data_o),
    .host_rsp_valid_o (ir_rsp_valid),
    .host_rdata_o     (ir_rdata),
    .mem_re_o         (mem_re),
    .mem_idx_o        (mem_idx)
  );

  // Write port is driven by the host alone
  wl_instr_mem i_instr_mem (
    .clk_i   (clk_i),
    .re_i    (mem_re),
    .ridx_i  (mem_idx),
    .we_i    (iw_req),
    .widx_i  (idx),
    .wdata_i (wdata),
    .rdata_o (mem_rdata),
    .w_ack_o (iw_ack)
  );

  //////////////////////////////////////////////////////////////////////
  // Data memory and control registers
  //////////////////////////////////////////////////////////////////////

  wl_data_mem i_data_mem (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (dm_req),
    .we_i        (dm_we),
    .idx_i       (dm_idx),
    .wdata_i     (wdata),
    .rsp_valid_o (dm_rsp_valid),
    .rdata_o     (dm_rdata)
  );

  wl_csr_regs i_csr_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (cr_req),
    .we_i        (cr_we),
    .idx_i       (cr_idx),
    .wdata_i     (wdata),
    .rsp_valid_o (cr_rsp_valid),
    .rdata_o     (cr_rdata),
    .eoc_o       (eoc_o)
  );

endmodule

/* tests/wl_tb.sv */
// Testbench for the memory subsystem
// Host operations come from a table and run alongside random instruction fetches,
// which are scored against a shadow copy of the instruction memory

`include "wl_macros.svh"

module wl_tb;

  import wl_pkg::*;

  localparam int MAX_OPS = 256;
  localparam int TIMEOUT_CYCLES = 100;

  logic     clk_i;
  logic     reset_i;
  logic     host_req_i;
  logic     host_we_i;
  wl_addr_t host_addr_i;
  wl_data_t host_wdata_i;
  logic     host_rsp_valid_o;
  wl_data_t host_rdata_o;
  logic     host_err_o;
  logic     fetch_valid_i;
  wl_addr_t fetch_addr_i;
  wl_data_t fetch_data_o;
  wl_data_t eoc_o;

  // Stimulus table: write flag, address, write data, expected data and error
  logic     op_we    [MAX_OPS];
  wl_addr_t op_addr  [MAX_OPS];
  wl_data_t op_wdata [MAX_OPS];
  wl_data_t op_rdata [MAX_OPS];
  logic     op_err   [MAX_OPS];
  // Response due exactly one cycle after the request
  logic     op_fixed [MAX_OPS];
  int       n_ops;

  // Instruction words written by the host so far
  wl_data_t shadow  [`WL_INSTR_WORDS];
  logic     written [`WL_INSTR_WORDS];

  logic [31:0] lfsr;
  logic        fetch_pend;
  wl_data_t    fetch_exp;

  wl_top wl_top_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .host_req_i       (host_req_i),
    .host_we_i        (host_we_i),
    .host_addr_i      (host_addr_i),
    .host_wdata_i     (host_wdata_i),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rdata_o     (host_rdata_o),
    .host_err_o       (host_err_o),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_data_o     (fetch_data_o),
    .eoc_o            (eoc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // Fill pattern over the whole address
  function automatic wl_data_t fill_word(input wl_addr_t addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic in_instr(input wl_addr_t addr);
    return addr >= `WL_INSTR_BASE && addr < `WL_INSTR_BASE + `WL_REGION_BYTES;
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      bits[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  task automatic add_op(input logic we, input wl_addr_t addr, input wl_data_t wdata,
                        input wl_data_t rdata, input logic err, input logic fixed);
    op_we[n_ops]    = we;
    op_addr[n_ops]  = addr;
    op_wdata[n_ops] = wdata;
    op_rdata[n_ops] = rdata;
    op_err[n_ops]   = err;
    op_fixed[n_ops] = fixed;
    n_ops++;
  endtask

  task automatic build_table();
    wl_addr_t a;
    wl_addr_t eoc_addr;
    wl_addr_t scr_addr;
    int k;
    n_ops    = 0;
    eoc_addr = `WL_CSR_BASE + 32'd4 * `WL_CSR_EOC_IDX;
    scr_addr = `WL_CSR_BASE + 32'd4 * `WL_CSR_SCRATCH_IDX;
    // Unmapped addresses, answered with an error
    add_op(1'b0, 32'h0000_0000, '0, '0, 1'b1, 1'b1);
    add_op(1'b1, 32'h0000_4000, 32'h1111_2222, '0, 1'b1, 1'b1);
    add_op(1'b0, 32'h0000_1400, '0, '0, 1'b1, 1'b1);
    add_op(1'b0, 32'h0000_0ffc, '0, '0, 1'b1, 1'b1);
    add_op(1'b0, 32'hffff_fffc, '0, '0, 1'b1, 1'b1);
    // Data memory, 18 words up to the last one of the region
    for (k = 0; k < 18; k++) begin
      a = `WL_DATA_BASE + 32'(k) * 32'd60;
      add_op(1'b1, a, fill_word(a), '0, 1'b0, 1'b1);
    end
    for (k = 0; k < 18; k++) begin
      a = `WL_DATA_BASE + 32'(k) * 32'd60;
      add_op(1'b0, a, '0, fill_word(a), 1'b0, 1'b1);
    end
    // Instruction memory, every fourth word
    for (k = 0; k < 64; k++) begin
      a = `WL_INSTR_BASE + 32'(k) * 32'd16;
      add_op(1'b1, a, fill_word(a), '0, 1'b0, 1'b1);
    end
    for (k = 0; k < 64; k++) begin
      a = `WL_INSTR_BASE + 32'(k) * 32'd16;
      add_op(1'b0, a, '0, fill_word(a), 1'b0, 1'b0);
    end
    // Control registers
    add_op(1'b1, eoc_addr, 32'hc001_d00d, '0, 1'b0, 1'b1);
    add_op(1'b1, scr_addr, 32'h1234_5678, '0, 1'b0, 1'b1);
    add_op(1'b0, scr_addr, '0, 32'h1234_5678, 1'b0, 1'b1);
    add_op(1'b0, eoc_addr, '0, 32'hc001_d00d, 1'b0, 1'b1);
    add_op(1'b0, `WL_CSR_BASE + 32'd8, '0, '0, 1'b0, 1'b1);
    add_op(1'b1, `WL_CSR_BASE + 32'd12, 32'hffff_ffff, '0, 1'b0, 1'b1);
    add_op(1'b0, `WL_CSR_BASE + 32'd12, '0, '0, 1'b0, 1'b1);
    add_op(1'b1, eoc_addr, 32'h0bad_cafe, '0, 1'b0, 1'b1);
    add_op(1'b0, eoc_addr, '0, 32'h0bad_cafe, 1'b0, 1'b1);
  endtask

  // Issue one table entry and wait for its response
  task automatic run_op(input int i);
    int   waited;
    logic done;
    logic fetch_at_grant;
    @(posedge clk_i);
    #1;
    host_req_i   = 1'b1;
    host_we_i    = op_we[i];
    host_addr_i  = op_addr[i];
    host_wdata_i = op_wdata[i];
    @(negedge clk_i);
    fetch_at_grant = fetch_valid_i;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      #1;
      host_req_i = 1'b0;
      @(negedge clk_i);
      waited++;
      // A fetch-free cycle grants the read, so its response is due now
      if (!op_fixed[i] && !fetch_at_grant) begin
        check_value("host_rsp_valid_o", 32'(host_rsp_valid_o), 32'd1);
      end
      if (host_rsp_valid_o) begin
        done = 1'b1;
      end else if (waited >= TIMEOUT_CYCLES) begin
        fail_run($sformatf("Timeout: no host response to operation %0d after %0d cycles",
                           i, TIMEOUT_CYCLES));
      end else begin
        fetch_at_grant = fetch_valid_i;
      end
    end
    if (op_fixed[i]) begin
      check_value("host response latency", waited, 32'd1);
    end else if (!op_we[i]) begin
      // Grant only in a cycle without a fetch
      check_value("fetch_valid_i at grant", 32'(fetch_at_grant), 32'd0);
    end
    check_value("host_err_o", 32'(host_err_o), 32'(op_err[i]));
    if (!op_we[i] || op_err[i]) begin
      check_value("host_rdata_o", host_rdata_o, op_rdata[i]);
    end
    if (op_we[i] && !op_err[i] && op_addr[i] == `WL_CSR_BASE + 32'd4 * `WL_CSR_EOC_IDX) begin
      check_value("eoc_o", eoc_o, op_wdata[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Fetch traffic and scoreboard
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] bits;
    logic        active;
    lfsr = 32'hb258_e316;
    forever begin
      @(posedge clk_i);
      active = !reset_i;
      #1;
      if (active) begin
        draw_bits(1, bits);
        fetch_valid_i = bits[0];
        draw_bits(8, bits);
        fetch_addr_i = `WL_INSTR_BASE + {22'd0, bits[7:0], 2'b00};
      end
    end
  end

  // Mid-cycle sampling; the shadow takes a host write after the fetch
  // of the same cycle has captured the old word
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (fetch_pend) begin
        check_value("fetch_data_o", fetch_data_o, fetch_exp);
      end
      fetch_pend = fetch_valid_i && written[fetch_addr_i[9:2]];
      fetch_exp  = shadow[fetch_addr_i[9:2]];
      if (host_req_i && host_we_i && in_instr(host_addr_i)) begin
        shadow[host_addr_i[9:2]]  = host_wdata_i;
        written[host_addr_i[9:2]] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    reset_i       = 1'b1;
    host_req_i    = 1'b0;
    host_we_i     = 1'b0;
    host_addr_i   = '0;
    host_wdata_i  = '0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    fetch_pend    = 1'b0;
    fetch_exp     = '0;
    for (i = 0; i < `WL_INSTR_WORDS; i++) begin
      written[i] = 1'b0;
    end
    build_table();
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    // State right after reset
    check_value("eoc_o", eoc_o, 32'd0);
    check_value("host_rsp_valid_o", 32'(host_rsp_valid_o), 32'd0);
    check_value("host_err_o", 32'(host_err_o), 32'd0);
    for (i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    // Let the last fetch be scored
    repeat (2) @(posedge clk_i);
    $display("Regression passed");
    $finish;
  end

endmodule

/* wl.f */
+incdir+include
src/wl_pkg.sv
src/wl_host_decode.sv
src/wl_instr_arbiter.sv
src/wl_instr_mem.sv
src/wl_data_mem.sv
src/wl_csr_regs.sv
src/wl_top.sv
tests/wl_tb.sv
